//--- include/pool_defines.svh
// Frame geometry and data width of the pooling layer
// Included by the packages, the RTL and the testbench; all values are
// compile-time and the input sizes must be even for 2x2 windows

`ifndef POOL_DEFINES_SVH
`define POOL_DEFINES_SVH

// ---------------------------------------------------------------------------
// Input frame
// ---------------------------------------------------------------------------

// Pixels per row
`define POOL_IN_WIDTH 8

// Rows per channel
`define POOL_IN_HEIGHT 8

// Channels per frame
`define POOL_CHANNELS 2

// Activation width in bits
`define POOL_DATA_WIDTH 8

// Output map after 2x2, stride 2
`define POOL_OUT_WIDTH (`POOL_IN_WIDTH / 2)
`define POOL_OUT_HEIGHT (`POOL_IN_HEIGHT / 2)

`endif

//--- design/pool_ctrl_pkg.sv
// Scan-control types of the pooling layer
// Coordinates and channel numbers that locate an activation in the frame;
// the decode stage produces them and the later stages read them

`include "pool_defines.svh"

package pool_ctrl_pkg;

    // Column or row index, wide enough for the larger input side
    typedef logic [$clog2((`POOL_IN_WIDTH > `POOL_IN_HEIGHT) ?
                          `POOL_IN_WIDTH : `POOL_IN_HEIGHT)-1:0] coord_t;

    // Channel index, same width as the output channel tag
    typedef logic [7:0] chan_t;

    // ------------------------------------------------------------------------
    // Position of one activation in raster order
    // ------------------------------------------------------------------------

    typedef struct packed {
        chan_t  chan;
        coord_t row;
        coord_t col;
    } scan_pos_t;

endpackage

//--- design/pool_data_pkg.sv
// Data-path types of the pooling layer
// Activation and partial-sum widths, and the beats that move between the
// decode, execute and result stages and onto the output stream

`include "pool_defines.svh"

package pool_data_pkg;

    import pool_ctrl_pkg::*;

    // One activation
    typedef logic [`POOL_DATA_WIDTH-1:0] pixel_t;

    // Sum of two and of four activations
    typedef logic [`POOL_DATA_WIDTH:0]   pair_sum_t;
    typedef logic [`POOL_DATA_WIDTH+1:0] quad_sum_t;

    // Decode to execute: tagged activation
    typedef struct packed {
        pixel_t    pixel;
        scan_pos_t pos;
        logic      pair_end;
        logic      win_end;
    } pixel_beat_t;

    // Execute to result and out: one window result
    typedef struct packed {
        pixel_t data;
        chan_t  chan;
        logic   last;
    } pool_beat_t;

endpackage

//--- design/pool_scan_decode.sv
// Decode stage of the pooling layer
// Accepts activations in raster order, tags each with its frame position
// and its role in the 2x2 window, and counts nonzero activations

`include "pool_defines.svh"

module pool_scan_decode
    import pool_ctrl_pkg::*;
    import pool_data_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        stall,
    input  pixel_t      in_data,
    input  logic        in_valid,
    output pixel_beat_t pix_beat,
    output logic        pix_valid,
    output logic [31:0] spike_count
);

    localparam coord_t LAST_COL  = coord_t'(`POOL_IN_WIDTH - 1);
    localparam coord_t LAST_ROW  = coord_t'(`POOL_IN_HEIGHT - 1);
    localparam chan_t  LAST_CHAN = chan_t'(`POOL_CHANNELS - 1);

    scan_pos_t pos;
    logic      accept;
    logic      pair_end;
    logic      win_end;

    // in_ready is the inverse of stall at the top level
    assign accept = in_valid && !stall;

    // Odd column closes a pair, odd row and odd column close a window
    assign pair_end = pos.col[0];
    assign win_end  = pos.col[0] && pos.row[0];

    // ------------------------------------------------------------------------
    // Scan position, x fastest, then y, then channel
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            pos <= '0;
        end else if (accept) begin
            if (pos.col == LAST_COL) begin
                pos.col <= '0;
                if (pos.row == LAST_ROW) begin
                    pos.row <= '0;
                    if (pos.chan == LAST_CHAN) begin
                        pos.chan <= '0;
                    end else begin
                        pos.chan <= pos.chan + chan_t'(1);
                    end
                end else begin
                    pos.row <= pos.row + coord_t'(1);
                end
            end else begin
                pos.col <= pos.col + coord_t'(1);
            end
        end
    end

    // ------------------------------------------------------------------------
    // Tagged beat register
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            pix_valid <= 1'b0;
        end else if (!stall) begin
            pix_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pix_beat.pixel    <= in_data;
            pix_beat.pos      <= pos;
            pix_beat.pair_end <= pair_end;
            pix_beat.win_end  <= win_end;
        end
    end

    // Spike counter
    always_ff @(posedge clk) begin
        if (reset) begin
            spike_count <= '0;
        end else if (accept && (in_data != '0)) begin
            spike_count <= spike_count + 32'd1;
        end
    end

endmodule

//--- design/pool_window_execute.sv
// Execute stage of the pooling layer
// Reduces each horizontal pair to a partial, parks even-row partials in a
// half-row buffer and completes the 2x2 window on the odd row, by maximum
// or by truncated mean as selected by pool_avg

`include "pool_defines.svh"

module pool_window_execute
    import pool_ctrl_pkg::*;
    import pool_data_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        stall,
    input  logic        pool_avg,
    input  pixel_beat_t pix_beat,
    input  logic        pix_valid,
    output pool_beat_t  win_beat,
    output logic        win_valid
);

    localparam int     BUF_IDX_W = (`POOL_OUT_WIDTH > 1) ? $clog2(`POOL_OUT_WIDTH) : 1;
    localparam coord_t LAST_COL  = coord_t'(`POOL_IN_WIDTH - 1);
    localparam coord_t LAST_ROW  = coord_t'(`POOL_IN_HEIGHT - 1);
    localparam chan_t  LAST_CHAN = chan_t'(`POOL_CHANNELS - 1);

    // Even-column pixel waiting for its partner
    pixel_t prev_pix;

    // One pair partial per output column
    pair_sum_t row_buf [`POOL_OUT_WIDTH];

    logic [BUF_IDX_W-1:0] buf_idx;
    pair_sum_t            pair_part;
    pair_sum_t            upper_part;
    quad_sum_t            quad_sum;
    pixel_t               win_result;
    logic                 advance;
    logic                 frame_last;

    assign advance = pix_valid && !stall;

    // Output column of the current pixel is col / 2
    assign buf_idx    = pix_beat.pos.col[BUF_IDX_W:1];
    assign upper_part = row_buf[buf_idx];

    assign frame_last = (pix_beat.pos.col == LAST_COL) &&
                        (pix_beat.pos.row == LAST_ROW) &&
                        (pix_beat.pos.chan == LAST_CHAN);

    // ------------------------------------------------------------------------
    // Pair and window reduction
    // ------------------------------------------------------------------------

    always_comb begin
        if (pool_avg) begin
            pair_part = pair_sum_t'(prev_pix) + pair_sum_t'(pix_beat.pixel);
        end else if (pix_beat.pixel > prev_pix) begin
            pair_part = pair_sum_t'(pix_beat.pixel);
        end else begin
            pair_part = pair_sum_t'(prev_pix);
        end

        quad_sum = quad_sum_t'(upper_part) + quad_sum_t'(pair_part);

        // Mean truncates, max partials never exceed the pixel range
        if (pool_avg) begin
            win_result = quad_sum[`POOL_DATA_WIDTH+1:2];
        end else if (pair_part > upper_part) begin
            win_result = pixel_t'(pair_part);
        end else begin
            win_result = pixel_t'(upper_part);
        end
    end

    // ------------------------------------------------------------------------
    // Pair holding and half-row buffer
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (advance) begin
            if (!pix_beat.pair_end) begin
                prev_pix <= pix_beat.pixel;
            end else if (!pix_beat.pos.row[0]) begin
                row_buf[buf_idx] <= pair_part;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Window result register
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            win_valid <= 1'b0;
        end else if (!stall) begin
            win_valid <= pix_valid && pix_beat.win_end;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && pix_beat.win_end) begin
            win_beat.data <= win_result;
            win_beat.chan <= pix_beat.pos.chan;
            win_beat.last <= frame_last;
        end
    end

endmodule

//--- design/pool_result_stage.sv
// Result stage of the pooling layer
// Output register of the pooled stream: takes a window result when empty
// or when its beat leaves, holds it under back-pressure, and counts the
// beats handed to the sink

module pool_result_stage
    import pool_data_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        out_ready,
    input  pool_beat_t  win_beat,
    input  logic        win_valid,
    output pool_beat_t  out_beat,
    output logic        out_valid,
    output logic [31:0] pool_ops_count
);

    // Beat leaves on this edge
    logic take;

    // Register is free for a new beat
    logic load;

    assign take = out_valid && out_ready;
    assign load = !out_valid || out_ready;

    // ------------------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------------------

    // Clears after a handshake with nothing new behind it
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= win_valid;
        end
    end

    // Beat stays put while the sink is not ready
    always_ff @(posedge clk) begin
        if (load && win_valid) begin
            out_beat <= win_beat;
        end
    end

    // ------------------------------------------------------------------------
    // Performance counter
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            pool_ops_count <= '0;
        end else if (take) begin
            pool_ops_count <= pool_ops_count + 32'd1;
        end
    end

endmodule

//--- design/snn_pooling.sv
// Streaming 2x2 pooling layer for the SNN accelerator
// Activations enter one per beat in raster order; each window leaves as one
// beat with its channel and a last-of-frame flag. pool_avg selects mean or
// max and changes only between frames

module snn_pooling
    import pool_data_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  pixel_t      in_data,
    input  logic        in_valid,
    output logic        in_ready,
    output pool_beat_t  out_beat,
    output logic        out_valid,
    input  logic        out_ready,
    input  logic        pool_avg,
    output logic [31:0] spike_count,
    output logic [31:0] pool_ops_count
);

    logic        stall;
    pixel_beat_t pix_beat;
    logic        pix_valid;
    pool_beat_t  win_beat;
    logic        win_valid;

    // Whole pipeline freezes while the output beat waits
    assign stall    = out_valid && !out_ready;
    assign in_ready = !stall;

    pool_scan_decode u_decode (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .in_data     (in_data),
        .in_valid    (in_valid),
        .pix_beat    (pix_beat),
        .pix_valid   (pix_valid),
        .spike_count (spike_count)
    );

    pool_window_execute u_execute (
        .clk       (clk),
        .reset     (reset),
        .stall     (stall),
        .pool_avg  (pool_avg),
        .pix_beat  (pix_beat),
        .pix_valid (pix_valid),
        .win_beat  (win_beat),
        .win_valid (win_valid)
    );

    pool_result_stage u_result (
        .clk            (clk),
        .reset          (reset),
        .out_ready      (out_ready),
        .win_beat       (win_beat),
        .win_valid      (win_valid),
        .out_beat       (out_beat),
        .out_valid      (out_valid),
        .pool_ops_count (pool_ops_count)
    );

endmodule

//--- sim/snn_pooling_asserts.sv
// Handshake checks on the pooled output stream
// Attached to every snn_pooling instance by the bind at the end of the file

`include "pool_defines.svh"

module pool_asserts_checker
    import pool_data_pkg::*;
(
    input logic       clk,
    input logic       reset,
    input logic       in_ready,
    input logic       out_valid,
    input logic       out_ready,
    input pool_beat_t out_beat
);

    // Output register comes out of reset empty
    out_idle_after_reset: assert property (@(posedge clk) reset |=> !out_valid)
        else $error("out_valid high in the cycle after reset");

    // A waiting beat neither drops nor changes
    out_beat_held: assert property (@(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_beat)))
        else $error("output beat dropped or changed while not taken");

    out_chan_range: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> (out_beat.chan < `POOL_CHANNELS))
        else $error("output channel tag out of range");

    // Input side stalls exactly when the output beat waits
    in_ready_is_not_stall: assert property (@(posedge clk) disable iff (reset)
        in_ready == !(out_valid && !out_ready))
        else $error("in_ready does not follow the stall condition");

endmodule

bind snn_pooling pool_asserts_checker u_asserts (
    .clk       (clk),
    .reset     (reset),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_beat  (out_beat)
);

//--- sim/snn_pooling_tb.sv
// Directed testbench for the streaming 2x2 pooling layer
// Sends whole frames, compares every output beat with a window model built
// from the stimulus, and repeats frames under random back-pressure

`include "pool_defines.svh"

module snn_pooling_tb
    import pool_ctrl_pkg::*;
    import pool_data_pkg::*;
();

    localparam int TOTAL_PIX = `POOL_IN_WIDTH * `POOL_IN_HEIGHT * `POOL_CHANNELS;
    localparam int OUT_BEATS = `POOL_OUT_WIDTH * `POOL_OUT_HEIGHT * `POOL_CHANNELS;
    localparam int CYCLE_LIMIT = 4000;

    logic        clk;
    logic        reset;
    pixel_t      in_data;
    logic        in_valid;
    logic        in_ready;
    pool_beat_t  out_beat;
    logic        out_valid;
    logic        out_ready;
    logic        pool_avg;
    logic [31:0] spike_count;
    logic [31:0] pool_ops_count;

    logic [31:0] lfsr;
    pixel_t      frame_pix [TOTAL_PIX];
    pool_beat_t  exp_q [$];
    logic [31:0] exp_spikes;
    logic [31:0] exp_ops;
    int          mismatches;
    int          failures;
    int          last_flags;
    bit          timed_out;

    snn_pooling dut (
        .clk            (clk),
        .reset          (reset),
        .in_data        (in_data),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .out_beat       (out_beat),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .pool_avg       (pool_avg),
        .spike_count    (spike_count),
        .pool_ops_count (pool_ops_count)
    );

    always #50 clk = ~clk;

    // ------------------------------------------------------------------------
    // Stimulus source and window model
    // ------------------------------------------------------------------------

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic draw_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    // About one pixel in four is left silent
    task automatic fill_frame(input bit zeros);
        logic [31:0] r;
        for (int i = 0; i < TOTAL_PIX; i++) begin
            draw_bits(2, r);
            if (zeros || r[1:0] == 2'b00) begin
                frame_pix[i] = '0;
            end else begin
                draw_bits(`POOL_DATA_WIDTH, r);
                frame_pix[i] = pixel_t'(r);
            end
        end
    endtask

    task automatic build_expected(input logic avg);
        int         base;
        pixel_t     p [4];
        quad_sum_t  sum;
        pool_beat_t beat;
        exp_q.delete();
        for (int c = 0; c < `POOL_CHANNELS; c++) begin
            for (int oy = 0; oy < `POOL_OUT_HEIGHT; oy++) begin
                for (int ox = 0; ox < `POOL_OUT_WIDTH; ox++) begin
                    base = c * `POOL_IN_WIDTH * `POOL_IN_HEIGHT
                         + 2 * oy * `POOL_IN_WIDTH + 2 * ox;
                    p[0] = frame_pix[base];
                    p[1] = frame_pix[base + 1];
                    p[2] = frame_pix[base + `POOL_IN_WIDTH];
                    p[3] = frame_pix[base + `POOL_IN_WIDTH + 1];
                    sum  = quad_sum_t'(p[0]) + quad_sum_t'(p[1])
                         + quad_sum_t'(p[2]) + quad_sum_t'(p[3]);
                    beat.data = p[0];
                    for (int k = 1; k < 4; k++) begin
                        if (p[k] > beat.data) beat.data = p[k];
                    end
                    if (avg) beat.data = pixel_t'(sum >> 2);
                    beat.chan = chan_t'(c);
                    beat.last = (c == `POOL_CHANNELS - 1) &&
                                (oy == `POOL_OUT_HEIGHT - 1) &&
                                (ox == `POOL_OUT_WIDTH - 1);
                    exp_q.push_back(beat);
                end
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Frame driver and output checker
    // ------------------------------------------------------------------------

    // Drives on the falling edge and samples 1 unit later while all is stable
    task automatic run_frame(input string name, input logic avg, input bit stress);
        int          sent;
        int          got;
        int          cycles;
        bit          hold;
        logic [31:0] r;
        pool_beat_t  exp_beat;
        if (timed_out) return;
        build_expected(avg);
        sent       = 0;
        got        = 0;
        cycles     = 0;
        hold       = 0;
        last_flags = 0;
        @(negedge clk);
        pool_avg = avg;
        while (got < OUT_BEATS) begin
            if (!hold) begin
                in_valid = (sent < TOTAL_PIX);
                if (sent < TOTAL_PIX) in_data = frame_pix[sent];
                if (stress && sent < TOTAL_PIX) begin
                    draw_bits(2, r);
                    in_valid = (r[1:0] != 2'b00);
                end
            end
            out_ready = 1'b1;
            if (stress) begin
                draw_bits(1, r);
                out_ready = r[0];
            end
            #1;
            if (in_valid && in_ready) begin
                if (in_data != '0) exp_spikes++;
                sent++;
            end
            hold = in_valid && !in_ready;
            if (out_valid && out_ready) begin
                exp_beat = exp_q[got];
                assert (out_beat.data == exp_beat.data) else begin
                    mismatches++;
                    $display("Mismatch in %s beat %0d data: expected %0d, actual %0d",
                             name, got, exp_beat.data, out_beat.data);
                end
                assert (out_beat.chan == exp_beat.chan) else begin
                    mismatches++;
                    $display("Mismatch in %s beat %0d channel: expected %0d, actual %0d",
                             name, got, exp_beat.chan, out_beat.chan);
                end
                assert (out_beat.last == exp_beat.last) else begin
                    mismatches++;
                    $display("Mismatch in %s beat %0d last: expected %0b, actual %0b",
                             name, got, exp_beat.last, out_beat.last);
                end
                if (out_beat.last) last_flags++;
                got++;
                exp_ops++;
            end
            cycles++;
            assert (cycles < CYCLE_LIMIT) else begin
                timed_out = 1;
                failures++;
                $display("Timeout in %s: %0d of %0d output beats after %0d cycles",
                         name, got, OUT_BEATS, cycles);
            end
            if (timed_out) break;
            @(negedge clk);
        end
        // Pipeline must drain with no extra beat behind the frame
        for (int k = 0; k < 4 && !timed_out; k++) begin
            @(negedge clk);
            in_valid  = 1'b0;
            out_ready = 1'b1;
            #1;
            assert (!out_valid) else begin
                failures++;
                $display("Extra output beat in %s after the last window", name);
            end
        end
        assert (timed_out || sent == TOTAL_PIX) else begin
            failures++;
            $display("In %s only %0d of %0d pixels were accepted", name, sent, TOTAL_PIX);
        end
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------

    task automatic test_max_pool;
        fill_frame(0);
        run_frame("max_pool", 1'b0, 1'b0);
    endtask

    task automatic test_avg_pool;
        fill_frame(0);
        run_frame("avg_pool", 1'b1, 1'b0);
    endtask

    // Same frame again with input gaps and a stuttering sink
    task automatic test_back_pressure;
        run_frame("back_pressure_avg", 1'b1, 1'b1);
        run_frame("back_pressure_max", 1'b0, 1'b1);
    endtask

    task automatic test_frame_tags;
        fill_frame(0);
        run_frame("frame_tags", 1'b0, 1'b1);
        assert (timed_out || last_flags == 1) else begin
            mismatches++;
            $display("Mismatch in frame_tags last count: expected 1, actual %0d", last_flags);
        end
    endtask

    task automatic test_counters;
        logic [31:0] spikes_before;
        if (timed_out) return;
        @(negedge clk);
        assert (spike_count == exp_spikes) else begin
            mismatches++;
            $display("Mismatch in counters spike_count: expected %0d, actual %0d",
                     exp_spikes, spike_count);
        end
        spikes_before = exp_spikes;
        fill_frame(1);
        run_frame("zero_frame", 1'b0, 1'b0);
        assert (spike_count == spikes_before) else begin
            mismatches++;
            $display("Mismatch in zero_frame spike_count: expected %0d, actual %0d",
                     spikes_before, spike_count);
        end
        assert (pool_ops_count == exp_ops) else begin
            mismatches++;
            $display("Mismatch in counters pool_ops_count: expected %0d, actual %0d",
                     exp_ops, pool_ops_count);
        end
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        in_data    = '0;
        in_valid   = 1'b0;
        out_ready  = 1'b0;
        pool_avg   = 1'b0;
        lfsr       = 32'h2f44_c0c6;
        exp_spikes = '0;
        exp_ops    = '0;
        mismatches = 0;
        failures   = 0;
        last_flags = 0;
        timed_out  = 0;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        test_max_pool();
        test_avg_pool();
        test_back_pressure();
        test_frame_tags();
        test_counters();
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- snn_pooling.f
+incdir+include
design/pool_ctrl_pkg.sv
design/pool_data_pkg.sv
design/pool_scan_decode.sv
design/pool_window_execute.sv
design/pool_result_stage.sv
design/snn_pooling.sv
sim/snn_pooling_asserts.sv
sim/snn_pooling_tb.sv
